//--- source/soc_macros.svh
// ************************************************
// SoC build constants for the 2x2 ring system
// Flit width, tile count, memory depth, host id
// ************************************************

`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// Payload bits in one flit
`define SOC_FLIT_DATA_W 32

// Compute tiles on the ring, node ids 0 up
`define SOC_NUM_TILES 4

// Scratch memory words per tile
`define SOC_MEM_WORDS 64

// Ring id of the host bridge, right after the tiles
`define SOC_HOST_NODE 4

`endif

//--- source/soc_pkg.sv
// ************************************************
// SoC package with NoC flit and packet types
// ************************************************

`default_nettype none

`include "soc_macros.svh"

package soc_pkg;

   typedef logic [2:0]                  node_id_t;
   typedef logic [5:0]                  word_addr_t;
   typedef logic [31:0]                 data_t;
   typedef logic [`SOC_FLIT_DATA_W-1:0] flit_data_t;

   typedef enum logic [1:0] {
      flit_head   = 2'd0,
      flit_body   = 2'd1,
      flit_last   = 2'd2,
      flit_single = 2'd3
   } flit_type_e;

   typedef enum logic [1:0] {
      cmd_rd_req = 2'd0,
      cmd_wr_req = 2'd1,
      cmd_rd_rsp = 2'd2,
      cmd_wr_ack = 2'd3
   } pkt_cmd_e;

   typedef enum logic [1:0] {
      tile_idle, tile_wait_data, tile_rsp_head, tile_rsp_data
   } tile_state_e;

   typedef enum logic [2:0] {
      br_idle, br_send_head, br_send_data, br_wait_reply, br_done
   } bridge_state_e;

   // Head flit: dest on top, then src, then cmd, word index at the bottom
   function automatic flit_data_t make_head(node_id_t dest, node_id_t src,
                                            pkt_cmd_e cmd, word_addr_t addr);
      flit_data_t f;
      f = '0;
      f[`SOC_FLIT_DATA_W-1 -: 3] = dest;
      f[`SOC_FLIT_DATA_W-4 -: 3] = src;
      f[`SOC_FLIT_DATA_W-7 -: 2] = cmd;
      f[5:0] = addr;
      return f;
   endfunction

   function automatic node_id_t head_dest(flit_data_t f);
      return f[`SOC_FLIT_DATA_W-1 -: 3];
   endfunction

   function automatic node_id_t head_src(flit_data_t f);
      return f[`SOC_FLIT_DATA_W-4 -: 3];
   endfunction

   function automatic pkt_cmd_e head_cmd(flit_data_t f);
      return pkt_cmd_e'(f[`SOC_FLIT_DATA_W-7 -: 2]);
   endfunction

   function automatic word_addr_t head_addr(flit_data_t f);
      return f[5:0];
   endfunction

endpackage

`default_nettype wire

//--- source/noc_link_if.sv
// ************************************************
// Ring link between two NoC stops
// Valid/ready handshake, one flit per transfer
// ************************************************

`timescale 1ns/100ps
`default_nettype none

interface noc_link_if
   import soc_pkg::*;
   ();

   logic       valid;
   logic       ready;
   flit_type_e flit_type;
   flit_data_t flit;

   // Sender side, holds flit until ready
   modport tx (
      output valid, flit_type, flit,
      input  ready
   );

   // Receiver side
   modport rx (
      input  valid, flit_type, flit,
      output ready
   );

endinterface

`default_nettype wire

//--- source/noc_ring_router.sv
// ************************************************
// Ring router stop with local eject and inject
// Registered outputs, wormhole lock on ring_out
// ************************************************

`timescale 1ns/100ps
`default_nettype none

module noc_ring_router
   import soc_pkg::*;
(
   input  wire logic     clk,
   input  wire logic     rst_n,
   input  wire node_id_t my_id,
   noc_link_if.rx        ring_in,
   noc_link_if.tx        ring_out,
   noc_link_if.rx        local_in,
   noc_link_if.tx        local_out
);

   logic in_head;
   logic in_last;
   logic in_to_local;
   logic in_route_q;
   logic loc_last;
   logic ro_busy_q;
   logic ro_local_q;
   logic ring_sel;
   logic local_sel;
   logic ring_xfer;
   logic local_xfer;

   // Header decode on the ring input
   assign in_head = ring_in.flit_type inside {flit_head, flit_single};
   assign in_last = ring_in.flit_type inside {flit_last, flit_single};
   assign loc_last = local_in.flit_type inside {flit_last, flit_single};

   // Body flits follow the route taken by their head
   assign in_to_local = in_head ? (head_dest(ring_in.flit) == my_id) : in_route_q;

   // Ring traffic first unless a local packet owns ring_out
   assign ring_sel = !in_to_local && !(ro_busy_q && ro_local_q);
   assign local_sel = ro_busy_q ? ro_local_q : !(ring_in.valid && !in_to_local);

   // Output slots load only when empty
   // keeps ready free of any path round the ring
   assign ring_in.ready = in_to_local ? !local_out.valid : (ring_sel && !ring_out.valid);
   assign local_in.ready = local_sel && !ring_out.valid;

   assign ring_xfer = ring_in.valid && ring_in.ready;
   assign local_xfer = local_in.valid && local_in.ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         in_route_q      <= 1'b0;
         ro_busy_q       <= 1'b0;
         ro_local_q      <= 1'b0;
         ring_out.valid  <= 1'b0;
         local_out.valid <= 1'b0;
      end else begin
         if (ring_xfer && in_head) begin
            in_route_q <= in_to_local;
         end
         // Lock ring_out until the final flit
         if (ring_xfer && !in_to_local) begin
            ro_busy_q  <= !in_last;
            ro_local_q <= 1'b0;
         end else if (local_xfer) begin
            ro_busy_q  <= !loc_last;
            ro_local_q <= 1'b1;
         end
         // Ring output slot
         if (ring_out.valid) begin
            ring_out.valid <= !ring_out.ready;
         end else begin
            ring_out.valid <= (ring_xfer && !in_to_local) || local_xfer;
         end
         // Eject slot toward the tile
         if (local_out.valid) begin
            local_out.valid <= !local_out.ready;
         end else begin
            local_out.valid <= ring_xfer && in_to_local;
         end
      end
   end

   // Flit payload registers
   always_ff @(posedge clk) begin
      if (ring_xfer && !in_to_local) begin
         ring_out.flit_type <= ring_in.flit_type;
         ring_out.flit      <= ring_in.flit;
      end else if (local_xfer) begin
         ring_out.flit_type <= local_in.flit_type;
         ring_out.flit      <= local_in.flit;
      end
      if (ring_xfer && in_to_local) begin
         local_out.flit_type <= ring_in.flit_type;
         local_out.flit      <= ring_in.flit;
      end
   end

endmodule

`default_nettype wire

//--- source/compute_tile.sv
// ************************************************
// Compute tile with 64-word scratch memory
// Serves read and write request packets
// ************************************************

`timescale 1ns/100ps
`default_nettype none

`include "soc_macros.svh"

module compute_tile
   import soc_pkg::*;
(
   input  wire logic     clk,
   input  wire logic     rst_n,
   input  wire node_id_t my_id,
   noc_link_if.rx        req,
   noc_link_if.tx        rsp
);

   tile_state_e state_q;
   node_id_t    src_q;
   word_addr_t  addr_q;
   logic        rd_q;
   data_t       mem [`SOC_MEM_WORDS];
   logic        req_xfer;
   logic        rsp_xfer;
   logic        req_is_wr;
   logic        mem_we;

   // Requests only taken while no reply is pending
   assign req.ready = (state_q == tile_idle) || (state_q == tile_wait_data);
   assign req_xfer = req.valid && req.ready;
   assign rsp_xfer = rsp.valid && rsp.ready;
   assign req_is_wr = head_cmd(req.flit) == cmd_wr_req;
   assign mem_we = req_xfer && (state_q == tile_wait_data);

   // Control FSM
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q   <= tile_idle;
         rd_q      <= 1'b0;
         rsp.valid <= 1'b0;
      end else begin
         case (state_q)
            tile_idle: begin
               if (req_xfer) begin
                  rd_q <= !req_is_wr;
                  if (req_is_wr) begin
                     state_q <= tile_wait_data;
                  end else begin
                     // Read is a single flit, reply right away
                     state_q   <= tile_rsp_head;
                     rsp.valid <= 1'b1;
                  end
               end
            end
            tile_wait_data: begin
               if (req_xfer) begin
                  state_q   <= tile_rsp_head;
                  rsp.valid <= 1'b1;
               end
            end
            tile_rsp_head: begin
               if (rsp_xfer) begin
                  if (rd_q) begin
                     state_q <= tile_rsp_data;
                  end else begin
                     state_q   <= tile_idle;
                     rsp.valid <= 1'b0;
                  end
               end
            end
            default: begin
               if (rsp_xfer) begin
                  state_q   <= tile_idle;
                  rsp.valid <= 1'b0;
               end
            end
         endcase
      end
   end

   // Request fields and reply flits
   always_ff @(posedge clk) begin
      if (req_xfer && (state_q == tile_idle)) begin
         src_q  <= head_src(req.flit);
         addr_q <= head_addr(req.flit);
      end
      if (req_xfer && (state_q == tile_idle) && !req_is_wr) begin
         rsp.flit_type <= flit_head;
         rsp.flit      <= make_head(head_src(req.flit), my_id, cmd_rd_rsp,
                                    head_addr(req.flit));
      end else if (mem_we) begin
         rsp.flit_type <= flit_single;
         rsp.flit      <= make_head(src_q, my_id, cmd_wr_ack, addr_q);
      end else if (rsp_xfer && (state_q == tile_rsp_head)) begin
         // Read data follows the reply head
         rsp.flit_type <= flit_last;
         rsp.flit      <= mem[addr_q];
      end
   end

   // Scratch memory, cleared on reset
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < `SOC_MEM_WORDS; i++) begin
            mem[i] <= '0;
         end
      end else if (mem_we) begin
         mem[addr_q] <= req.flit;
      end
   end

endmodule

`default_nettype wire

//--- source/host_apb_bridge.sv
// ************************************************
// Host APB bridge onto the ring
// One access at a time, ends on the reply packet
// ************************************************

`timescale 1ns/100ps
`default_nettype none

`include "soc_macros.svh"

module host_apb_bridge
   import soc_pkg::*;
(
   input  wire logic        clk,
   input  wire logic        rst_n,
   input  wire logic        psel,
   input  wire logic        penable,
   input  wire logic        pwrite,
   input  wire logic [10:0] paddr,
   input  wire data_t       pwdata,
   output logic             pready,
   output logic             pslverr,
   output data_t            prdata,
   noc_link_if.rx           ring_in,
   noc_link_if.tx           ring_out
);

   localparam node_id_t host_id = node_id_t'(`SOC_HOST_NODE);

   bridge_state_e state_q;
   data_t         prdata_q;
   logic          access;
   logic          node_ok;
   logic          in_head;
   logic          in_last;
   logic          in_to_host;
   logic          in_route_q;
   logic          fwd_busy_q;
   logic          own_busy;
   logic          own_start;
   logic          fwd_xfer;
   logic          rsp_xfer;
   logic          ro_xfer;

   assign access = psel && penable;
   // Only tile nodes answer
   assign node_ok = int'(paddr[10:8]) < `SOC_NUM_TILES;

   assign in_head = ring_in.flit_type inside {flit_head, flit_single};
   assign in_last = ring_in.flit_type inside {flit_last, flit_single};
   assign in_to_host = in_head ? (head_dest(ring_in.flit) == host_id) : in_route_q;

   // Own request owns ring_out from head to data
   assign own_busy = state_q inside {br_send_head, br_send_data};
   assign own_start = (state_q == br_idle) && access && node_ok && !ring_out.valid &&
                      !fwd_busy_q && !(ring_in.valid && !in_to_host);

   // Replies consumed only while waiting, other traffic passes on
   assign ring_in.ready = in_to_host ? (state_q == br_wait_reply)
                                     : (!ring_out.valid && !own_busy);
   assign fwd_xfer = ring_in.valid && ring_in.ready && !in_to_host;
   assign rsp_xfer = ring_in.valid && ring_in.ready && in_to_host;
   assign ro_xfer = ring_out.valid && ring_out.ready;

   // Bad node ends at once, otherwise one cycle in done
   assign pslverr = (state_q == br_idle) && access && !node_ok;
   assign pready = (state_q == br_done) || pslverr;
   assign prdata = prdata_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q        <= br_idle;
         in_route_q     <= 1'b0;
         fwd_busy_q     <= 1'b0;
         ring_out.valid <= 1'b0;
      end else begin
         if (ring_in.valid && ring_in.ready && in_head) begin
            in_route_q <= in_to_host;
         end
         if (fwd_xfer) begin
            fwd_busy_q <= !in_last;
         end
         if (own_start || fwd_xfer) begin
            ring_out.valid <= 1'b1;
         end else if (ro_xfer) begin
            // Write data goes out straight behind its head
            ring_out.valid <= (state_q == br_send_head) && pwrite;
         end
         case (state_q)
            br_idle:       if (own_start) state_q <= br_send_head;
            br_send_head: begin
               if (ro_xfer) begin
                  if (pwrite) begin
                     state_q <= br_send_data;
                  end else begin
                     state_q <= br_wait_reply;
                  end
               end
            end
            br_send_data:  if (ro_xfer) state_q <= br_wait_reply;
            br_wait_reply: if (rsp_xfer && in_last) state_q <= br_done;
            default:       state_q <= br_idle;
         endcase
      end
   end

   // Outgoing flits and read data capture
   always_ff @(posedge clk) begin
      if (own_start) begin
         if (pwrite) begin
            ring_out.flit_type <= flit_head;
            ring_out.flit      <= make_head(paddr[10:8], host_id, cmd_wr_req, paddr[7:2]);
         end else begin
            ring_out.flit_type <= flit_single;
            ring_out.flit      <= make_head(paddr[10:8], host_id, cmd_rd_req, paddr[7:2]);
         end
      end else if (fwd_xfer) begin
         ring_out.flit_type <= ring_in.flit_type;
         ring_out.flit      <= ring_in.flit;
      end else if (ro_xfer && (state_q == br_send_head)) begin
         ring_out.flit_type <= flit_last;
         ring_out.flit      <= pwdata;
      end
      // Read reply data sits in its last flit
      if (rsp_xfer && (ring_in.flit_type == flit_last)) begin
         prdata_q <= ring_in.flit;
      end
   end

endmodule

`default_nettype wire

//--- source/system_2x2.sv
// ************************************************
// 2x2 tile system on a one-way ring
// Four router stops with tiles, host bridge as fifth
// ************************************************

`timescale 1ns/100ps
`default_nettype none

`include "soc_macros.svh"

module system_2x2
   import soc_pkg::*;
(
   input  wire logic        clk,
   input  wire logic        rst_n,
   input  wire logic        psel,
   input  wire logic        penable,
   input  wire logic        pwrite,
   input  wire logic [10:0] paddr,
   input  wire data_t       pwdata,
   output logic             pready,
   output logic             pslverr,
   output data_t            prdata
);

   // Ring link k feeds stop k, the last one feeds the host
   noc_link_if ring_link [`SOC_NUM_TILES+1] ();
   // Router to tile requests, tile to router replies
   noc_link_if tile_req [`SOC_NUM_TILES] ();
   noc_link_if tile_rsp [`SOC_NUM_TILES] ();

   for (genvar i = 0; i < `SOC_NUM_TILES; i++) begin : g_tile
      noc_ring_router i_router (
         .clk       (clk),
         .rst_n     (rst_n),
         .my_id     (node_id_t'(i)),
         .ring_in   (ring_link[i]),
         .ring_out  (ring_link[i+1]),
         .local_in  (tile_rsp[i]),
         .local_out (tile_req[i])
      );

      compute_tile i_tile (
         .clk   (clk),
         .rst_n (rst_n),
         .my_id (node_id_t'(i)),
         .req   (tile_req[i]),
         .rsp   (tile_rsp[i])
      );
   end

   // Host closes the ring back to stop 0
   host_apb_bridge i_host (
      .clk      (clk),
      .rst_n    (rst_n),
      .psel     (psel),
      .penable  (penable),
      .pwrite   (pwrite),
      .paddr    (paddr),
      .pwdata   (pwdata),
      .pready   (pready),
      .pslverr  (pslverr),
      .prdata   (prdata),
      .ring_in  (ring_link[`SOC_NUM_TILES]),
      .ring_out (ring_link[0])
   );

endmodule

`default_nettype wire

//--- verif/system_2x2_chk.sv
// ************************************************
// Protocol checker for the APB port and ring links
// Bound into the host bridge and every router
// ************************************************

`timescale 1ns/100ps
`default_nettype none

module system_2x2_chk
   import soc_pkg::*;
(
   input wire logic        clk,
   input wire logic        rst_n,
   input wire logic        psel,
   input wire logic        penable,
   input wire logic        pready,
   input wire logic        pslverr,
   input wire logic        valid,
   input wire logic        ready,
   input wire logic [1:0]  flit_type,
   input wire flit_data_t  flit
);

   // Failed assertions, read by the testbench at the end
   int fail_cnt;

   initial fail_cnt = 0;

   // Completion only inside an access phase
   apb_ready_in_access: assert property (@(posedge clk) disable iff (!rst_n)
      pready |-> (psel && penable))
      else begin
         fail_cnt++;
         $error("pready high outside an APB access phase");
      end

   // Error response comes with completion and puts no packet on the ring
   apb_err_with_ready: assert property (@(posedge clk) disable iff (!rst_n)
      pslverr |-> pready ##1 !valid)
      else begin
         fail_cnt++;
         $error("pslverr without pready, or a packet sent for a bad node");
      end

   // Sender holds the flit while stalled
   link_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
      (valid && !ready) |=> (valid && $stable(flit_type) && $stable(flit)))
      else begin
         fail_cnt++;
         $error("ring link flit changed or dropped while ready was low");
      end

endmodule

bind host_apb_bridge system_2x2_chk i_chk (
   .clk       (clk),
   .rst_n     (rst_n),
   .psel      (psel),
   .penable   (penable),
   .pready    (pready),
   .pslverr   (pslverr),
   .valid     (ring_out.valid),
   .ready     (ring_out.ready),
   .flit_type (ring_out.flit_type),
   .flit      (ring_out.flit)
);

// Routers have no APB side, those inputs sit at zero
bind noc_ring_router system_2x2_chk i_chk (
   .clk       (clk),
   .rst_n     (rst_n),
   .psel      (1'b0),
   .penable   (1'b0),
   .pready    (1'b0),
   .pslverr   (1'b0),
   .valid     (ring_out.valid),
   .ready     (ring_out.ready),
   .flit_type (ring_out.flit_type),
   .flit      (ring_out.flit)
);

`default_nettype wire

//--- verif/tb_system_2x2.sv
// ************************************************
// Testbench for the 2x2 ring tile system
// APB host accesses against a reference memory
// ************************************************

`timescale 1ns/100ps
`default_nettype none

`include "soc_macros.svh"

module tb_system_2x2
   import soc_pkg::*;
();

   localparam int timeout_cycles = 200;

   logic        clk;
   logic        rst_n;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [10:0] paddr;
   data_t       pwdata;
   logic        pready;
   logic        pslverr;
   data_t       prdata;

   // Expected contents of every tile memory
   data_t       ref_mem [`SOC_NUM_TILES][`SOC_MEM_WORDS];
   logic [31:0] rng_state;
   int          checks;
   int          errors;
   int          test_err_base;
   int          chk_fails;
   logic        hung;

   system_2x2 i_dut (
      .clk     (clk),
      .rst_n   (rst_n),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .pready  (pready),
      .pslverr (pslverr),
      .prdata  (prdata)
   );

   always #50 clk = ~clk;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic check_value(input string name, input data_t got, input data_t exp);
      checks++;
      assert (got == exp) else begin
         $display("error at %0t: %s = %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   // One APB transfer, setup then access until pready
   task automatic apb_access(input logic wr, input logic [2:0] node, input logic [5:0] word,
                             input data_t wdata, output data_t rdata, output logic err);
      int n;
      rdata = '0;
      err = 1'b0;
      if (!hung) begin
         @(posedge clk);
         psel    <= 1'b1;
         penable <= 1'b0;
         pwrite  <= wr;
         paddr   <= {node, word, 2'b00};
         pwdata  <= wdata;
         @(posedge clk);
         penable <= 1'b1;
         n = 0;
         // Sampled mid-cycle where pready is settled
         do begin
            @(negedge clk);
            n++;
         end while (!pready && n < timeout_cycles);
         if (pready) begin
            rdata = prdata;
            err   = pslverr;
         end else begin
            $display("APB access to node %0d word %0d got no pready in %0d cycles",
                     node, word, timeout_cycles);
            hung = 1'b1;
            errors++;
         end
         @(posedge clk);
         psel    <= 1'b0;
         penable <= 1'b0;
      end
   endtask

   // Nodes past the last tile must answer with an error
   task automatic write_word(input logic [2:0] node, input logic [5:0] word,
                             input data_t data);
      data_t rd;
      logic  err;
      apb_access(1'b1, node, word, data, rd, err);
      if (!hung) begin
         check_value("pslverr", data_t'(err), data_t'(int'(node) >= `SOC_NUM_TILES));
         if (int'(node) < `SOC_NUM_TILES) begin
            ref_mem[node[1:0]][word] = data;
         end
      end
   endtask

   task automatic read_word(input logic [2:0] node, input logic [5:0] word);
      data_t rd;
      logic  err;
      apb_access(1'b0, node, word, '0, rd, err);
      if (!hung) begin
         check_value("pslverr", data_t'(err), data_t'(int'(node) >= `SOC_NUM_TILES));
         if (int'(node) < `SOC_NUM_TILES) begin
            check_value("prdata", rd, ref_mem[node[1:0]][word]);
         end
      end
   endtask

   task automatic end_test(input string name);
      $display("test %s: %s, %0d errors", name,
               (errors == test_err_base) ? "ok" : "bad", errors - test_err_base);
      test_err_base = errors;
   endtask

   initial begin
      logic [31:0] r;
      clk = 1'b0;
      rst_n = 1'b0;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = '0;
      pwdata = '0;
      hung = 1'b0;
      checks = 0;
      errors = 0;
      test_err_base = 0;
      rng_state = 32'd9;
      for (int t = 0; t < `SOC_NUM_TILES; t++) begin
         for (int w = 0; w < `SOC_MEM_WORDS; w++) begin
            ref_mem[t][w] = '0;
         end
      end
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;

      // Every word of every tile starts at zero
      for (int t = 0; t < `SOC_NUM_TILES; t++) begin
         for (int w = 0; w < `SOC_MEM_WORDS; w++) begin
            read_word(3'(t), 6'(w));
         end
      end
      end_test("reset_zero");

      for (int t = 0; t < `SOC_NUM_TILES; t++) begin
         rng_state = xorshift(rng_state);
         write_word(3'(t), 6'(5 + t), rng_state);
         read_word(3'(t), 6'(5 + t));
      end
      end_test("write_read");

      // Same index in all tiles, all values kept apart
      for (int t = 0; t < `SOC_NUM_TILES; t++) begin
         rng_state = xorshift(rng_state);
         write_word(3'(t), 6'd12, rng_state);
      end
      for (int t = 0; t < `SOC_NUM_TILES; t++) begin
         read_word(3'(t), 6'd12);
      end
      end_test("tile_independent");

      for (int n = 5; n < 8; n++) begin
         rng_state = xorshift(rng_state);
         write_word(3'(n), 6'd12, rng_state);
         read_word(3'(n), 6'd12);
      end
      for (int t = 0; t < `SOC_NUM_TILES; t++) begin
         read_word(3'(t), 6'd12);
      end
      end_test("bad_node");

      // Random mix across all tiles
      repeat (40) begin
         rng_state = xorshift(rng_state);
         r = rng_state;
         if (r[8]) begin
            rng_state = xorshift(rng_state);
            write_word({1'b0, r[1:0]}, r[7:2], rng_state);
         end else begin
            read_word({1'b0, r[1:0]}, r[7:2]);
         end
      end
      end_test("random");

      // Protocol failures seen by the bound checkers
      chk_fails = i_dut.i_host.i_chk.fail_cnt + i_dut.g_tile[0].i_router.i_chk.fail_cnt
                + i_dut.g_tile[1].i_router.i_chk.fail_cnt
                + i_dut.g_tile[2].i_router.i_chk.fail_cnt
                + i_dut.g_tile[3].i_router.i_chk.fail_cnt;
      if (chk_fails != 0) begin
         $display("%0d protocol assertions failed in the bound checkers", chk_fails);
         errors += chk_fails;
      end
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- files.f
+incdir+source
source/soc_pkg.sv
source/noc_link_if.sv
source/noc_ring_router.sv
source/compute_tile.sv
source/host_apb_bridge.sv
source/system_2x2.sv
verif/system_2x2_chk.sv
verif/tb_system_2x2.sv

//--- run.sh
#!/bin/sh
# Compile and run the 2x2 ring system testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f files.f --top-module tb_system_2x2 -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "Test completed successfully"; then
   exit 0
fi
exit 1
